//--- source/cnn_dims_pkg.sv
package cnn_dims_pkg;

   // Frame geometry
   localparam int FRAME_W     = 8;                     // Pixels per row
   localparam int FRAME_H     = 8;                     // Rows per frame
   localparam int FRAME_SIZE  = FRAME_W * FRAME_H;     // 64 pixels
   localparam int PIX_IDX_W   = 6;                     // Pixel index width
   localparam int POS_W       = 3;                     // Row/col counter width
   localparam int DELAY_W     = 12;                    // Blanking counters

   // Channels and taps
   localparam int N_CH        = 4;                     // Output channels in parallel
   localparam int CH_W        = 2;                     // Channel index width
   localparam int N_TAP       = 9;                     // 3x3 kernel

   // Arithmetic widths
   localparam int ACT_BITS    = 8;                     // Pixel / activation
   localparam int WGT_BITS    = 8;                     // Signed weight
   localparam int WGT_WORD_W  = N_TAP * WGT_BITS;      // One kernel, 72 bits
   localparam int PARAM_BITS  = 16;                    // Signed scale or bias
   localparam int ACC_BITS    = 20;                    // MAC accumulator
   localparam int SCALE_SHIFT = 8;                     // Post-scale shift
   localparam int FMAP_W      = N_CH * ACT_BITS;       // Feature-map word, 32 bits

endpackage

//--- source/cnn_types_pkg.sv
package cnn_types_pkg;

   // Frame controller phases
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,   // Waiting for start
      ST_VSYNC = 3'd1,   // Vertical blanking, params copied here
      ST_DATA  = 3'd2,   // One pixel per cycle
      ST_HSYNC = 3'd3,   // Gap between rows
      ST_DONE  = 3'd4    // End-of-frame pulse
   } ctrl_state_e;

   // Host write target
   typedef enum logic [1:0] {
      PRM_WEIGHT = 2'd0, // 72-bit kernel word
      PRM_SCALE  = 2'd1, // Low 16 bits
      PRM_BIAS   = 2'd2  // Low 16 bits
   } prm_sel_e;

endpackage

//--- source/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl (
   input  logic                             i_clk,
   input  logic                             i_rstn,
   input  logic                             i_start,
   input  logic [cnn_dims_pkg::DELAY_W-1:0] i_vsync_delay,
   input  logic [cnn_dims_pkg::DELAY_W-1:0] i_hsync_delay,
   output cnn_types_pkg::ctrl_state_e       o_state,
   output logic [cnn_dims_pkg::DELAY_W-1:0] o_vsync_cnt,
   output logic                             o_data_run,
   output logic [cnn_dims_pkg::POS_W-1:0]   o_row,
   output logic [cnn_dims_pkg::POS_W-1:0]   o_col,
   output logic                             o_end_frame
);
   import cnn_dims_pkg::*;
   import cnn_types_pkg::*;

   ctrl_state_e        state_nxt;
   logic [DELAY_W-1:0] blank_cnt;                        // Shared by both blanking phases
   logic               last_col;
   logic               last_row;
   logic               vsync_end;
   logic               hsync_end;

   assign last_col    = (o_col == POS_W'(FRAME_W - 1));
   assign last_row    = (o_row == POS_W'(FRAME_H - 1));
   assign vsync_end   = (blank_cnt == i_vsync_delay - 1'b1);
   assign hsync_end   = (blank_cnt == i_hsync_delay - 1'b1);
   assign o_vsync_cnt = blank_cnt;                       // Loader qualifies with state

   // -------------------------------------------------------------------
   // Next state
   // -------------------------------------------------------------------
   always_comb begin
      state_nxt = o_state;
      case (o_state)
         ST_IDLE: begin
            if (i_start)
               state_nxt = ST_VSYNC;
         end
         ST_VSYNC: begin
            if (vsync_end)
               state_nxt = ST_DATA;
         end
         ST_DATA: begin
            if (last_col) begin
               if (last_row)
                  state_nxt = ST_DONE;                   // No gap after the last row
               else if (i_hsync_delay != '0)
                  state_nxt = ST_HSYNC;                  // Zero delay: rows back to back
            end
         end
         ST_HSYNC: begin
            if (hsync_end)
               state_nxt = ST_DATA;
         end
         ST_DONE:  state_nxt = ST_IDLE;                  // Single cycle
         default:  state_nxt = ST_IDLE;
      endcase
   end

   // -------------------------------------------------------------------
   // State, counters and registered flags
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         o_state     <= ST_IDLE;
         blank_cnt   <= '0;
         o_row       <= '0;
         o_col       <= '0;
         o_data_run  <= 1'b0;
         o_end_frame <= 1'b0;
      end else begin
         o_state     <= state_nxt;
         o_data_run  <= (state_nxt == ST_DATA);          // Aligned with state
         o_end_frame <= (state_nxt == ST_DONE);
         if (state_nxt != o_state)
            blank_cnt <= '0;                             // Restart on phase change
         else if (o_state == ST_VSYNC || o_state == ST_HSYNC)
            blank_cnt <= blank_cnt + 1'b1;
         if (o_state == ST_IDLE) begin
            o_row <= '0;
            o_col <= '0;
         end else if (o_state == ST_DATA) begin
            if (last_col) begin
               o_col <= '0;
               o_row <= o_row + 1'b1;                    // Wraps to 0 after last row
            end else begin
               o_col <= o_col + 1'b1;
            end
         end
      end
   end

endmodule

//--- source/param_loader.sv
`timescale 1ns/1ps

module param_loader (
   input  logic                                                  i_clk,
   input  logic                                                  i_rstn,
   input  logic                                                  i_prm_we,
   input  cnn_types_pkg::prm_sel_e                               i_prm_sel,
   input  logic [cnn_dims_pkg::CH_W-1:0]                         i_prm_addr,
   input  logic [cnn_dims_pkg::WGT_WORD_W-1:0]                   i_prm_wdata,
   input  cnn_types_pkg::ctrl_state_e                            i_state,
   input  logic [cnn_dims_pkg::DELAY_W-1:0]                      i_vsync_cnt,
   output logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::WGT_WORD_W-1:0] o_weights,
   output logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::PARAM_BITS-1:0] o_scales,
   output logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::PARAM_BITS-1:0] o_biases
);
   import cnn_dims_pkg::*;
   import cnn_types_pkg::*;

   logic [WGT_WORD_W-1:0] wgt_buf   [N_CH];             // Host-written buffers
   logic [PARAM_BITS-1:0] scale_buf [N_CH];
   logic [PARAM_BITS-1:0] bias_buf  [N_CH];

   logic                  rd_en;
   logic [CH_W-1:0]       rd_addr;
   logic                  rd_en_d;                      // Lines up with buffer output
   logic [CH_W-1:0]       rd_addr_d;
   logic [WGT_WORD_W-1:0] wgt_q;                        // Registered buffer reads
   logic [PARAM_BITS-1:0] scale_q;
   logic [PARAM_BITS-1:0] bias_q;

   // -------------------------------------------------------------------
   // Host write port
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_prm_we) begin
         case (i_prm_sel)
            PRM_WEIGHT: wgt_buf[i_prm_addr]   <= i_prm_wdata;
            PRM_SCALE:  scale_buf[i_prm_addr] <= i_prm_wdata[PARAM_BITS-1:0];
            PRM_BIAS:   bias_buf[i_prm_addr]  <= i_prm_wdata[PARAM_BITS-1:0];
            default:    ;                                // Unused code, ignored
         endcase
      end
   end

   // -------------------------------------------------------------------
   // Copy during vertical blanking, one channel per count
   // -------------------------------------------------------------------
   assign rd_en   = (i_state == ST_VSYNC) && (i_vsync_cnt < DELAY_W'(N_CH));
   assign rd_addr = i_vsync_cnt[CH_W-1:0];

   always_ff @(posedge i_clk) begin
      if (rd_en) begin
         wgt_q   <= wgt_buf[rd_addr];                    // One-cycle read latency
         scale_q <= scale_buf[rd_addr];
         bias_q  <= bias_buf[rd_addr];
      end
   end

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         rd_en_d   <= 1'b0;
         rd_addr_d <= '0;
      end else begin
         rd_en_d   <= rd_en;
         rd_addr_d <= rd_addr;
      end
   end

   // Working registers, held across frames
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         o_weights <= '0;
         o_scales  <= '0;
         o_biases  <= '0;
      end else if (rd_en_d) begin
         o_weights[rd_addr_d*WGT_WORD_W +: WGT_WORD_W] <= wgt_q;
         o_scales[rd_addr_d*PARAM_BITS +: PARAM_BITS]  <= scale_q;
         o_biases[rd_addr_d*PARAM_BITS +: PARAM_BITS]  <= bias_q;
      end
   end

endmodule

//--- source/window_builder.sv
`timescale 1ns/1ps

module window_builder (
   input  logic                                                 i_clk,
   input  logic                                                 i_rstn,
   input  logic                                                 i_data_run,
   input  logic [cnn_dims_pkg::POS_W-1:0]                       i_row,
   input  logic [cnn_dims_pkg::POS_W-1:0]                       i_col,
   input  logic [cnn_dims_pkg::ACT_BITS-1:0]                    i_pixel,
   output logic                                                 o_win_valid,
   output logic [cnn_dims_pkg::N_TAP*cnn_dims_pkg::ACT_BITS-1:0] o_window
);
   import cnn_dims_pkg::*;

   logic [ACT_BITS-1:0]       line1   [FRAME_W];        // Row - 1
   logic [ACT_BITS-1:0]       line2   [FRAME_W];        // Row - 2
   logic [ACT_BITS-1:0]       col_now [3];              // Current column, index dr
   logic [ACT_BITS-1:0]       col_d1  [3];              // Column - 1
   logic [ACT_BITS-1:0]       col_d2  [3];              // Column - 2
   logic [ACT_BITS-1:0]       tap_sel;
   logic [N_TAP*ACT_BITS-1:0] win_nxt;

   assign col_now[0] = i_pixel;
   assign col_now[1] = line1[i_col];
   assign col_now[2] = line2[i_col];

   // Tap (dr, dc) at bits 8*(3*dr+dc), zero outside the frame
   always_comb begin
      tap_sel = '0;
      for (int dr = 0; dr < 3; dr++) begin
         for (int dc = 0; dc < 3; dc++) begin
            case (dc)
               0:       tap_sel = col_now[dr];
               1:       tap_sel = col_d1[dr];
               default: tap_sel = col_d2[dr];
            endcase
            if (i_row < dr || i_col < dc)
               tap_sel = '0;                             // Border padding
            win_nxt[(dr*3+dc)*ACT_BITS +: ACT_BITS] = tap_sel;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn)
         o_win_valid <= 1'b0;
      else
         o_win_valid <= i_data_run;                      // Same edge as the pixel
   end

   always_ff @(posedge i_clk) begin
      if (i_data_run) begin
         o_window     <= win_nxt;
         line1[i_col] <= i_pixel;
         line2[i_col] <= line1[i_col];                   // Old row moves down
         col_d1       <= col_now;
         col_d2       <= col_d1;
      end
   end

endmodule

//--- source/conv_engine.sv
`timescale 1ns/1ps

module conv_engine (
   input  logic                                                    i_clk,
   input  logic                                                    i_rstn,
   input  logic                                                    i_win_valid,
   input  logic [cnn_dims_pkg::N_TAP*cnn_dims_pkg::ACT_BITS-1:0]    i_window,
   input  logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::WGT_WORD_W-1:0]   i_weights,
   input  logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::PARAM_BITS-1:0]   i_scales,
   input  logic [cnn_dims_pkg::N_CH*cnn_dims_pkg::PARAM_BITS-1:0]   i_biases,
   output logic                                                    o_res_valid,
   output logic [cnn_dims_pkg::FMAP_W-1:0]                         o_result
);
   import cnn_dims_pkg::*;

   logic signed [ACC_BITS-1:0]            mac    [N_CH];  // 9-tap sum
   logic signed [ACC_BITS+PARAM_BITS-1:0] scaled [N_CH];  // Full product
   logic signed [ACC_BITS+PARAM_BITS-1:0] biased [N_CH];  // After shift and bias
   logic        [FMAP_W-1:0]              res_nxt;

   // -------------------------------------------------------------------
   // MAC, scale, bias, clip per channel
   // -------------------------------------------------------------------
   always_comb begin
      res_nxt = '0;
      for (int ch = 0; ch < N_CH; ch++) begin
         mac[ch] = '0;
         for (int t = 0; t < N_TAP; t++) begin
            mac[ch] = mac[ch]
                    + $signed({1'b0, i_window[t*ACT_BITS +: ACT_BITS]})  // Unsigned pixel
                    * $signed(i_weights[ch*WGT_WORD_W + t*WGT_BITS +: WGT_BITS]);
         end
         scaled[ch] = mac[ch] * $signed(i_scales[ch*PARAM_BITS +: PARAM_BITS]);
         biased[ch] = (scaled[ch] >>> SCALE_SHIFT)
                    + $signed(i_biases[ch*PARAM_BITS +: PARAM_BITS]);
         if (biased[ch] < 0)
            res_nxt[ch*ACT_BITS +: ACT_BITS] = '0;       // Clamp low
         else if (biased[ch] > 2**ACT_BITS - 1)
            res_nxt[ch*ACT_BITS +: ACT_BITS] = '1;       // Clamp at 255
         else
            res_nxt[ch*ACT_BITS +: ACT_BITS] = biased[ch][ACT_BITS-1:0];
      end
   end

   // -------------------------------------------------------------------
   // Output register, one window per cycle
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn)
         o_res_valid <= 1'b0;
      else
         o_res_valid <= i_win_valid;
   end

   always_ff @(posedge i_clk) begin
      if (i_win_valid)
         o_result <= res_nxt;                            // Lane ch at bits 8*ch
   end

endmodule

//--- source/fmap_store.sv
`timescale 1ns/1ps

module fmap_store (
   input  logic                               i_clk,
   input  logic                               i_rstn,
   input  logic                               i_start,
   input  logic                               i_res_valid,
   input  logic [cnn_dims_pkg::FMAP_W-1:0]    i_result,
   input  logic [cnn_dims_pkg::PIX_IDX_W-1:0] i_rd_addr,
   output logic [cnn_dims_pkg::FMAP_W-1:0]    o_rd_data,
   output logic                               o_layer_done
);
   import cnn_dims_pkg::*;

   logic [FMAP_W-1:0]    fmap_mem [FRAME_SIZE];         // One word per pixel
   logic [PIX_IDX_W-1:0] wr_ptr;

   always_ff @(posedge i_clk or negedge i_rstn) begin
      if (!i_rstn) begin
         wr_ptr       <= '0;
         o_layer_done <= 1'b0;
      end else if (i_start) begin
         wr_ptr       <= '0;                             // New frame
         o_layer_done <= 1'b0;
      end else if (i_res_valid) begin
         if (wr_ptr == PIX_IDX_W'(FRAME_SIZE - 1)) begin
            wr_ptr       <= '0;
            o_layer_done <= 1'b1;                        // Sticky until next start
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_res_valid)
         fmap_mem[wr_ptr] <= i_result;
      o_rd_data <= fmap_mem[i_rd_addr];                  // Registered host read
   end

endmodule

//--- source/cnn_top.sv
`timescale 1ns/1ps

module cnn_top (
   input  logic                                 i_clk,
   input  logic                                 i_rstn,
   input  logic                                 i_prm_we,
   input  cnn_types_pkg::prm_sel_e              i_prm_sel,
   input  logic [cnn_dims_pkg::CH_W-1:0]        i_prm_addr,
   input  logic [cnn_dims_pkg::WGT_WORD_W-1:0]  i_prm_wdata,
   input  logic                                 i_start,
   input  logic [cnn_dims_pkg::DELAY_W-1:0]     i_vsync_delay,
   input  logic [cnn_dims_pkg::DELAY_W-1:0]     i_hsync_delay,
   input  logic [cnn_dims_pkg::ACT_BITS-1:0]    i_pixel,
   input  logic [cnn_dims_pkg::PIX_IDX_W-1:0]   i_rd_addr,
   output logic                                 o_data_run,
   output logic                                 o_end_frame,
   output logic                                 o_layer_done,
   output logic [cnn_dims_pkg::FMAP_W-1:0]      o_rd_data
);
   import cnn_dims_pkg::*;
   import cnn_types_pkg::*;

   ctrl_state_e                  state;
   logic [DELAY_W-1:0]           vsync_cnt;
   logic [POS_W-1:0]             row;
   logic [POS_W-1:0]             col;
   logic                         win_valid;
   logic [N_TAP*ACT_BITS-1:0]    window;
   logic                         res_valid;
   logic [FMAP_W-1:0]            result;
   logic [N_CH*WGT_WORD_W-1:0]   weights;           // Working copies
   logic [N_CH*PARAM_BITS-1:0]   scales;
   logic [N_CH*PARAM_BITS-1:0]   biases;

   frame_ctrl u_frame_ctrl (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_start(i_start),
      .i_vsync_delay(i_vsync_delay), .i_hsync_delay(i_hsync_delay),
      .o_state(state), .o_vsync_cnt(vsync_cnt), .o_data_run(o_data_run),
      .o_row(row), .o_col(col), .o_end_frame(o_end_frame)
   );

   param_loader u_param_loader (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_prm_we(i_prm_we), .i_prm_sel(i_prm_sel),
      .i_prm_addr(i_prm_addr), .i_prm_wdata(i_prm_wdata), .i_state(state),
      .i_vsync_cnt(vsync_cnt), .o_weights(weights), .o_scales(scales), .o_biases(biases)
   );

   window_builder u_window_builder (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_data_run(o_data_run), .i_row(row), .i_col(col),
      .i_pixel(i_pixel), .o_win_valid(win_valid), .o_window(window)
   );

   conv_engine u_conv_engine (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_win_valid(win_valid), .i_window(window),
      .i_weights(weights), .i_scales(scales), .i_biases(biases),
      .o_res_valid(res_valid), .o_result(result)
   );

   fmap_store u_fmap_store (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_start(i_start), .i_res_valid(res_valid),
      .i_result(result), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
      .o_layer_done(o_layer_done)
   );

endmodule

//--- testbench/tb_cnn_top.sv
`timescale 1ns/1ps

module tb_cnn_top;
   import cnn_dims_pkg::*;
   import cnn_types_pkg::*;

   localparam int VS_A      = 10;                       // Blanking of frames 1 to 3
   localparam int HS_A      = 4;
   localparam int VS_B      = 20;                       // Second-parameter frame
   localparam int HS_B      = 9;
   localparam int FRAME_A   = VS_A + FRAME_SIZE + (FRAME_H - 1) * HS_A;
   localparam int FRAME_B   = VS_B + FRAME_SIZE + (FRAME_H - 1) * HS_B;
   localparam int TIMEOUT   = 5 * (3 * FRAME_A + FRAME_B) + 2000;  // Margin for writes and reads
   localparam int CHK_REF   = 0;                        // Expected word from reference
   localparam int CHK_IDENT = 1;                        // Pixel in every lane
   localparam int CHK_CLAMP = 2;                        // Lanes 0 and 1 at 255 and lanes 2 and 3 at 0

   logic                  clk = 1'b0;
   logic                  rstn;
   logic                  prm_we;
   prm_sel_e              prm_sel;
   logic [CH_W-1:0]       prm_addr;
   logic [WGT_WORD_W-1:0] prm_wdata;
   logic                  start;
   logic [DELAY_W-1:0]    vsync_delay;
   logic [DELAY_W-1:0]    hsync_delay;
   logic [ACT_BITS-1:0]   pixel;
   logic [PIX_IDX_W-1:0]  rd_addr;
   logic                  o_data_run;
   logic                  o_end_frame;
   logic                  o_layer_done;
   logic [FMAP_W-1:0]     o_rd_data;

   logic [WGT_WORD_W-1:0] wgt [N_CH];                   // Model copies of host params
   logic [PARAM_BITS-1:0] scl [N_CH];
   logic [PARAM_BITS-1:0] bia [N_CH];
   logic [ACT_BITS-1:0]   pix [FRAME_SIZE];             // Frame in raster order
   logic [31:0]           lfsr = 32'h9aa89ad6;
   int errors = 0;
   int test_base = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycles = 0;
   int run_cycles = 0;                                  // Monitor counts
   int run_starts = 0;
   int run_len = 0;                                     // Length of the current run
   int full_runs = 0;                                   // Runs of exactly FRAME_W cycles
   int end_pulses = 0;
   logic prev_run = 1'b0;

   cnn_top uut (
      .i_clk(clk), .i_rstn(rstn), .i_prm_we(prm_we), .i_prm_sel(prm_sel),
      .i_prm_addr(prm_addr), .i_prm_wdata(prm_wdata), .i_start(start),
      .i_vsync_delay(vsync_delay), .i_hsync_delay(hsync_delay), .i_pixel(pixel),
      .i_rd_addr(rd_addr), .o_data_run(o_data_run), .o_end_frame(o_end_frame),
      .o_layer_done(o_layer_done), .o_rd_data(o_rd_data)
   );

   always #2 clk = ~clk;                                // 4 ns period

   // ----------------------------------------------------------------------
   // Run-level monitor and cycle limit on the falling edge
   // ----------------------------------------------------------------------
   always @(negedge clk) begin
      if (rstn) begin
         if (o_data_run)
            run_cycles++;
         if (o_data_run && !prev_run)
            run_starts++;                               // New row run
         if (o_data_run) begin
            run_len++;
         end else begin
            if (prev_run && run_len == FRAME_W)
               full_runs++;
            run_len = 0;
         end
         if (o_end_frame)
            end_pulses++;
      end
      prev_run = o_data_run;
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: run stopped after %0d cycles without finishing", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Expected output word at (r, c) from causal 3x3 MAC, scale, shift, bias and clip
   function automatic logic [FMAP_W-1:0] ref_word(input int r, input int c);
      logic [FMAP_W-1:0] word;
      longint acc;
      longint val;
      int p;
      word = '0;
      for (int ch = 0; ch < N_CH; ch++) begin
         acc = 0;
         for (int t = 0; t < N_TAP; t++) begin
            p = ((r - t / 3) < 0 || (c - t % 3) < 0) ? 0
              : int'(pix[(r - t / 3) * FRAME_W + c - t % 3]);  // Zero border
            acc += p * longint'($signed(wgt[ch][t*WGT_BITS +: WGT_BITS]));
         end
         val = ((acc * longint'($signed(scl[ch]))) >>> SCALE_SHIFT)
             + longint'($signed(bia[ch]));
         word[ch*ACT_BITS +: ACT_BITS] = (val < 0) ? 8'd0 : (val > 255) ? 8'd255 : val[7:0];
      end
      return word;
   endfunction

   task automatic check_fmap(input string name, input logic [FMAP_W-1:0] got,
                             input logic [FMAP_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         errors++;
         $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      if (errors == test_base) begin
         tests_passed++;
         $display("Test %s: passed", name);
      end else begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, errors - test_base);
      end
      test_base = errors;
   endtask

   task automatic set_pixels(input logic [ACT_BITS-1:0] or_mask);
      for (int i = 0; i < FRAME_SIZE; i++)
         pix[i] = ACT_BITS'(rand_bits(ACT_BITS)) | or_mask;
   endtask

   task automatic set_random_params();
      logic [31:0] w;
      for (int ch = 0; ch < N_CH; ch++) begin
         for (int t = 0; t < N_TAP; t++) begin
            w = rand_bits(4);
            wgt[ch][t*WGT_BITS +: WGT_BITS] = {{4{w[3]}}, w[3:0]};  // -8 to 7
         end
         w = rand_bits(6);
         scl[ch] = {{10{w[5]}}, w[5:0]};                // -32 to 31
         w = rand_bits(8);
         bia[ch] = {{8{w[7]}}, w[7:0]};
      end
   endtask

   task automatic write_one(input prm_sel_e sel, input int addr,
                            input logic [WGT_WORD_W-1:0] data);
      @(posedge clk);
      #0.5;
      prm_we    = 1'b1;
      prm_sel   = sel;
      prm_addr  = CH_W'(addr);
      prm_wdata = data;
   endtask

   task automatic write_params();
      for (int ch = 0; ch < N_CH; ch++) begin
         write_one(PRM_WEIGHT, ch, wgt[ch]);
         write_one(PRM_SCALE, ch, {56'd0, scl[ch]});
         write_one(PRM_BIAS, ch, {56'd0, bia[ch]});
      end
      @(posedge clk);
      #0.5 prm_we = 1'b0;
   endtask

   // Start a frame, feed pixels on each data-run cycle and wait for layer done
   task automatic run_frame(input int vs, input int hs);
      int idx;
      vsync_delay = DELAY_W'(vs);
      hsync_delay = DELAY_W'(hs);
      @(posedge clk);
      #0.5 start = 1'b1;
      @(posedge clk);
      #0.5 start = 1'b0;
      check_flag("o_layer_done after i_start", o_layer_done, 1'b0);
      idx = 0;
      while (idx < FRAME_SIZE) begin
         @(posedge clk);
         #0.5;
         if (o_data_run) begin
            pixel = pix[idx];                           // Sampled at the next edge
            idx++;
         end
      end
      while (!o_layer_done) begin
         @(posedge clk);
         #0.5;
      end
   endtask

   task automatic read_and_check(input int mode);
      logic [FMAP_W-1:0] exp;
      for (int a = 0; a < FRAME_SIZE; a++) begin
         @(posedge clk);
         #0.5 rd_addr = PIX_IDX_W'(a);
         @(posedge clk);
         #0.5;                                          // Registered read
         case (mode)
            CHK_IDENT: exp = {N_CH{pix[a]}};
            CHK_CLAMP: exp = {8'd0, 8'd0, 8'hff, 8'hff};
            default:   exp = ref_word(a / FRAME_W, a % FRAME_W);
         endcase
         check_fmap($sformatf("o_rd_data[%0d]", a), o_rd_data, exp);
      end
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      int rc0;
      int rs0;
      int fr0;
      int ep0;
      rstn        = 1'b0;
      prm_we      = 1'b0;
      prm_sel     = PRM_WEIGHT;
      prm_addr    = '0;
      prm_wdata   = '0;
      start       = 1'b0;
      vsync_delay = DELAY_W'(VS_A);
      hsync_delay = DELAY_W'(HS_A);
      pixel       = '0;
      rd_addr     = '0;
      repeat (4) @(posedge clk);
      #0.5 rstn = 1'b1;

      for (int i = 0; i < 10; i++) begin                // Idle without start
         @(posedge clk);
         #0.5;
         check_flag("o_data_run", o_data_run, 1'b0);
         check_flag("o_end_frame", o_end_frame, 1'b0);
         check_flag("o_layer_done", o_layer_done, 1'b0);
      end
      end_test("1 reset state");

      for (int ch = 0; ch < N_CH; ch++) begin
         wgt[ch] = 72'h1;                               // Tap 0 only
         scl[ch] = 16'h0100;
         bia[ch] = 16'h0000;
      end
      set_pixels(8'h00);
      write_params();
      run_frame(VS_A, HS_A);
      read_and_check(CHK_IDENT);
      end_test("2 identity kernel");

      set_random_params();
      set_pixels(8'h00);
      write_params();
      rc0 = run_cycles;
      rs0 = run_starts;
      fr0 = full_runs;
      ep0 = end_pulses;
      run_frame(VS_A, HS_A);
      read_and_check(CHK_REF);
      end_test("3 random frame");
      check_count("o_data_run high cycles", run_cycles - rc0, FRAME_SIZE);
      check_count("o_data_run runs", run_starts - rs0, FRAME_H);
      check_count("o_data_run runs of FRAME_W cycles", full_runs - fr0, FRAME_H);
      check_count("o_end_frame pulses", end_pulses - ep0, 1);
      end_test("5 frame timing");

      for (int ch = 0; ch < N_CH; ch++) begin
         wgt[ch] = (ch < 2) ? {N_TAP{8'd127}} : {N_TAP{8'd1}};
         scl[ch] = (ch < 2) ? 16'h0100 : 16'h8000;      // Upper lanes get -32768
         bia[ch] = (ch < 2) ? 16'h0000 : 16'hff9c;      // -100
      end
      set_pixels(8'h80);
      write_params();
      run_frame(VS_A, HS_A);
      read_and_check(CHK_CLAMP);
      end_test("4 clamp range");

      set_random_params();
      set_pixels(8'h00);
      write_params();
      check_flag("o_layer_done before i_start", o_layer_done, 1'b1);
      run_frame(VS_B, HS_B);
      read_and_check(CHK_REF);
      end_test("6 second frame");

      $display("Tests passed: %0d, failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- project.f
source/cnn_dims_pkg.sv
source/cnn_types_pkg.sv
source/frame_ctrl.sv
source/param_loader.sv
source/window_builder.sv
source/conv_engine.sv
source/fmap_store.sv
source/cnn_top.sv
testbench/tb_cnn_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CNN layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cnn_top -f project.f \
   --Mdir obj_dir -o tb_cnn_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_cnn_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
   exit 0
fi
exit 1
